/* hw/rv32i_pkg.sv */
/*
 * RV32I shared types and constants
 * Major opcode, funct3 and ALU operation enums
 * Instruction format overlays, decoded control struct
 * Data memory request struct, halt word and register count
 */
`default_nettype none

package rv32i_pkg;

  localparam logic [31:0] HALT_INSTR = 32'h7800d073;
  localparam int          NUM_REGS   = 32;

  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  // Stores reuse these codes for SB, SH and SW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct3_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Instruction word overlays, MSB first
  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    reg_funct3_t funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } rtype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    branch_t    funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  // Decoded datapath controls for one instruction
  typedef struct packed {
    alu_op_t     alu_op;
    logic [1:0]  alu_a_sel;
    logic [1:0]  alu_b_sel;
    logic [1:0]  w_sel;
    logic        wen;
    logic        dren;
    logic        dwen;
    logic        branch;
    branch_t     branch_type;
    logic        jump;
    logic        j_sel;
    load_t       load_type;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_sb;
    logic [31:0] imm_uj;
    logic [31:0] imm_u;
    logic        halt;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byte_en;
    logic        ren;
    logic        wen;
  } mem_req_t;

endpackage

`default_nettype wire

/* hw/rv32i_alu.sv */
/*
 * RV32I ALU
 * Add, subtract, shifts, logic ops and signed/unsigned compare
 */
`timescale 1ns/1ps
`default_nettype none

module rv32i_alu
  import rv32i_pkg::*;
(
  input  wire alu_op_t     op_i,
  input  wire logic [31:0] a_i,
  input  wire logic [31:0] b_i,
  output logic      [31:0] result_o
);

  logic [4:0] shamt;

  // Only the low five bits of b shift
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {31'd0, a_i < b_i};
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

/* hw/rv32i_reg_file.sv */
/*
 * RV32I register file
 * Two asynchronous read ports, one write port, x0 reads as zero
 */
`timescale 1ns/1ps
`default_nettype none

module rv32i_reg_file
  import rv32i_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic [4:0]  rs1_i,
  input  wire logic [4:0]  rs2_i,
  input  wire logic [4:0]  rd_i,
  input  wire logic        wen_i,
  input  wire logic [31:0] wdata_i,
  output logic      [31:0] rs1_data_o,
  output logic      [31:0] rs2_data_o
);

  // No storage behind x0
  logic [31:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

endmodule

`default_nettype wire

/* hw/rv32i_control_unit.sv */
/*
 * RV32I control unit
 * Combinational decode of one instruction word into the control struct,
 * sign-extended immediates and load/store byte enables
 */
`timescale 1ns/1ps
`default_nettype none

module rv32i_control_unit
  import rv32i_pkg::*;
(
  input  wire logic [31:0] instr_i,
  input  wire logic [1:0]  byte_offset_i,
  output ctrl_t            ctrl_o,
  output logic [3:0]       byte_en_o
);

  itype_t      instr_i_fmt;
  stype_t      instr_s_fmt;
  rtype_t      instr_r_fmt;
  sbtype_t     instr_sb_fmt;
  utype_t      instr_u_fmt;
  ujtype_t     instr_uj_fmt;
  opcode_t     opcode;
  imm_funct3_t imm_f3;
  load_t       mem_f3;

  assign instr_i_fmt  = itype_t'(instr_i);
  assign instr_s_fmt  = stype_t'(instr_i);
  assign instr_r_fmt  = rtype_t'(instr_i);
  assign instr_sb_fmt = sbtype_t'(instr_i);
  assign instr_u_fmt  = utype_t'(instr_i);
  assign instr_uj_fmt = ujtype_t'(instr_i);

  assign opcode = instr_i_fmt.opcode;
  assign imm_f3 = imm_funct3_t'(instr_i_fmt.funct3);
  assign mem_f3 = load_t'(instr_i_fmt.funct3);

  always_comb begin
    ctrl_o = '0;

    ctrl_o.rs1 = instr_r_fmt.rs1;
    ctrl_o.rs2 = instr_r_fmt.rs2;
    ctrl_o.rd  = instr_r_fmt.rd;

    // Sign-extended immediates for every format
    ctrl_o.imm_i  = {{20{instr_i_fmt.imm11_00[11]}}, instr_i_fmt.imm11_00};
    ctrl_o.imm_s  = {{20{instr_s_fmt.imm11_05[6]}}, instr_s_fmt.imm11_05,
                     instr_s_fmt.imm04_00};
    ctrl_o.imm_sb = {{19{instr_sb_fmt.imm12}}, instr_sb_fmt.imm12, instr_sb_fmt.imm11,
                     instr_sb_fmt.imm10_05, instr_sb_fmt.imm04_01, 1'b0};
    ctrl_o.imm_uj = {{11{instr_uj_fmt.imm20}}, instr_uj_fmt.imm20, instr_uj_fmt.imm19_12,
                     instr_uj_fmt.imm11, instr_uj_fmt.imm10_01, 1'b0};
    ctrl_o.imm_u  = {instr_u_fmt.imm31_12, 12'b0};

    ctrl_o.branch_type = instr_sb_fmt.funct3;
    ctrl_o.load_type   = mem_f3;

    ctrl_o.dren   = (opcode == LOAD);
    ctrl_o.dwen   = (opcode == STORE);
    ctrl_o.branch = (opcode == BRANCH);
    ctrl_o.jump   = (opcode == JAL) || (opcode == JALR);
    ctrl_o.j_sel  = (opcode == JAL);

    // Operand A is rs1 except for AUIPC
    ctrl_o.alu_a_sel = (opcode == AUIPC) ? 2'd2 : 2'd0;

    case (opcode)
      STORE:       ctrl_o.alu_b_sel = 2'd0;
      REGREG:      ctrl_o.alu_b_sel = 2'd1;
      IMMED, LOAD: ctrl_o.alu_b_sel = 2'd2;
      AUIPC:       ctrl_o.alu_b_sel = 2'd3;
      default:     ctrl_o.alu_b_sel = 2'd0;
    endcase

    // Writeback source and register write enable
    case (opcode)
      LOAD: begin
        ctrl_o.w_sel = 2'd0;
        ctrl_o.wen   = 1'b1;
      end
      JAL, JALR: begin
        ctrl_o.w_sel = 2'd1;
        ctrl_o.wen   = 1'b1;
      end
      LUI: begin
        ctrl_o.w_sel = 2'd2;
        ctrl_o.wen   = 1'b1;
      end
      IMMED, AUIPC, REGREG: begin
        ctrl_o.w_sel = 2'd3;
        ctrl_o.wen   = 1'b1;
      end
      default: begin
        ctrl_o.w_sel = 2'd0;
        ctrl_o.wen   = 1'b0;
      end
    endcase

    // ALU operation with bit 30 picking SUB and SRA
    ctrl_o.alu_op = ALU_ADD;
    if (opcode == IMMED) begin
      case (imm_f3)
        ADDI:    ctrl_o.alu_op = ALU_ADD;
        SLLI:    ctrl_o.alu_op = ALU_SLL;
        SLTI:    ctrl_o.alu_op = ALU_SLT;
        SLTIU:   ctrl_o.alu_op = ALU_SLTU;
        XORI:    ctrl_o.alu_op = ALU_XOR;
        SRI:     ctrl_o.alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
        ORI:     ctrl_o.alu_op = ALU_OR;
        ANDI:    ctrl_o.alu_op = ALU_AND;
        default: ctrl_o.alu_op = ALU_ADD;
      endcase
    end else if (opcode == REGREG) begin
      case (instr_r_fmt.funct3)
        ADDSUB:  ctrl_o.alu_op = instr_i[30] ? ALU_SUB : ALU_ADD;
        SLL:     ctrl_o.alu_op = ALU_SLL;
        SLT:     ctrl_o.alu_op = ALU_SLT;
        SLTU:    ctrl_o.alu_op = ALU_SLTU;
        XOR:     ctrl_o.alu_op = ALU_XOR;
        SR:      ctrl_o.alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
        OR:      ctrl_o.alu_op = ALU_OR;
        AND:     ctrl_o.alu_op = ALU_AND;
        default: ctrl_o.alu_op = ALU_ADD;
      endcase
    end

    ctrl_o.halt = (instr_i == HALT_INSTR);
  end

  // Lanes follow the computed address and misaligned halves get none
  always_comb begin
    case (mem_f3)
      LB, LBU: byte_en_o = 4'b0001 << byte_offset_i;
      LH, LHU: begin
        case (byte_offset_i)
          2'b00:   byte_en_o = 4'b0011;
          2'b10:   byte_en_o = 4'b1100;
          default: byte_en_o = 4'b0000;
        endcase
      end
      LW:      byte_en_o = 4'b1111;
      default: byte_en_o = 4'b0000;
    endcase
  end

endmodule

`default_nettype wire

/* hw/rv32i_core.sv */
/*
 * Single-cycle RV32I core
 * Program counter, halt latch, branch compare, operand and writeback muxes,
 * store lane shift and load extension around decode, register file and ALU
 */
`timescale 1ns/1ps
`default_nettype none

module rv32i_core
  import rv32i_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic [31:0] instr_i,
  input  wire logic        instr_valid_i,
  input  wire logic [31:0] rdata_i,
  output logic      [31:0] pc_o,
  output mem_req_t         mem_req_o,
  output logic             wb_en_o,
  output logic      [4:0]  wb_rd_o,
  output logic      [31:0] wb_data_o,
  output logic             halted_o
);

  ctrl_t       ctrl;
  logic [3:0]  byte_en;
  logic [1:0]  byte_offset;
  logic [31:0] pc;
  logic [31:0] pc_next;
  logic        halted;
  logic        active;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] load_shifted;
  logic [31:0] load_data;
  logic        branch_taken;

  // An instruction executes only while valid and not halted
  assign active      = instr_valid_i && !halted;
  assign byte_offset = alu_result[1:0];

  rv32i_control_unit rv32i_control_unit_inst (
    .instr_i       (instr_i),
    .byte_offset_i (byte_offset),
    .ctrl_o        (ctrl),
    .byte_en_o     (byte_en)
  );

  rv32i_reg_file rv32i_reg_file_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_i      (ctrl.rs1),
    .rs2_i      (ctrl.rs2),
    .rd_i       (wb_rd_o),
    .wen_i      (wb_en_o),
    .wdata_i    (wb_data_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  assign alu_a = (ctrl.alu_a_sel == 2'd2) ? pc : rs1_data;

  always_comb begin
    case (ctrl.alu_b_sel)
      2'd0:    alu_b = ctrl.imm_s;
      2'd1:    alu_b = rs2_data;
      2'd2:    alu_b = ctrl.imm_i;
      default: alu_b = ctrl.imm_u;
    endcase
  end

  rv32i_alu rv32i_alu_inst (
    .op_i     (ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  always_comb begin
    case (ctrl.branch_type)
      BEQ:     branch_taken = (rs1_data == rs2_data);
      BNE:     branch_taken = (rs1_data != rs2_data);
      BLT:     branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      BGE:     branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      BLTU:    branch_taken = (rs1_data < rs2_data);
      BGEU:    branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

  // JALR target has bit 0 cleared
  always_comb begin
    if (ctrl.jump) begin
      pc_next = ctrl.j_sel ? (pc + ctrl.imm_uj) : ((rs1_data + ctrl.imm_i) & ~32'd1);
    end else if (ctrl.branch && branch_taken) begin
      pc_next = pc + ctrl.imm_sb;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  // The halt word itself leaves pc in place
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (active) begin
      if (ctrl.halt) begin
        halted <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

  // Selected lane moved down to bit 0 before extension
  assign load_shifted = rdata_i >> {byte_offset, 3'b000};

  always_comb begin
    case (ctrl.load_type)
      LB:      load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
      LBU:     load_data = {24'd0, load_shifted[7:0]};
      LH:      load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
      LHU:     load_data = {16'd0, load_shifted[15:0]};
      default: load_data = rdata_i;
    endcase
  end

  always_comb begin
    case (ctrl.w_sel)
      2'd0:    wb_data_o = load_data;
      2'd1:    wb_data_o = pc + 32'd4;
      2'd2:    wb_data_o = ctrl.imm_u;
      default: wb_data_o = alu_result;
    endcase
  end

  assign wb_en_o = ctrl.wen && active;
  assign wb_rd_o = ctrl.rd;

  always_comb begin
    mem_req_o.addr    = alu_result;
    mem_req_o.wdata   = rs2_data << {byte_offset, 3'b000};
    mem_req_o.byte_en = byte_en;
    mem_req_o.ren     = ctrl.dren && active;
    mem_req_o.wen     = ctrl.dwen && active;
  end

  assign pc_o     = pc;
  assign halted_o = halted;

endmodule

`default_nettype wire

/* dv/rv32i_core_sva.sv */
/*
 * Bound assertions for the RV32I core
 * Memory strobes, program counter alignment and halt behavior
 */
`timescale 1ns/1ps
`default_nettype none

module rv32i_core_sva
  import rv32i_pkg::*;
(
  input wire logic        clk_i,
  input wire logic        rst_n_i,
  input wire logic [31:0] instr_i,
  input wire logic        instr_valid_i,
  input wire logic [31:0] pc_o,
  input wire mem_req_t    mem_req_o,
  input wire logic        wb_en_o,
  input wire logic        halted_o
);

  a_no_read_and_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mem_req_o.ren && mem_req_o.wen))
    else $error("Memory read and write strobes high together");

  a_quiet_when_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted_o |-> !(mem_req_o.ren || mem_req_o.wen || wb_en_o))
    else $error("Strobe high while halted");

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_o[1:0] == 2'b00)
    else $error("Program counter not word aligned");

  a_pc_held_when_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted_o |=> $stable(pc_o))
    else $error("Program counter moved while halted");

  // Halt word latches on the following edge
  a_halt_latches: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (instr_valid_i && !halted_o && instr_i == HALT_INSTR) |=> halted_o)
    else $error("Halt word did not set halted");

endmodule

bind rv32i_core rv32i_core_sva rv32i_core_sva_inst (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .instr_i       (instr_i),
  .instr_valid_i (instr_valid_i),
  .pc_o          (pc_o),
  .mem_req_o     (mem_req_o),
  .wb_en_o       (wb_en_o),
  .halted_o      (halted_o)
);

`default_nettype wire

/* dv/rv32i_core_tb.sv */
/*
 * Testbench for the single-cycle RV32I core
 * Clock and reset, vector-driven stimulus from the vectors file,
 * output compare task, cycle-count timeout
 */
`timescale 1ns/1ps
`default_nettype none

module rv32i_core_tb
  import rv32i_pkg::*;
();

  localparam int NUM_VECS   = 60;
  localparam int VEC_WORDS  = 13;
  localparam int MAX_CYCLES = NUM_VECS + 20;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] instr;
  logic        instr_valid;
  logic [31:0] rdata;
  logic [31:0] pc;
  mem_req_t    mem_req;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        halted;
  int          cycle_count = 0;

  // Thirteen words per vector in the order instr valid rdata pc wb_en wb_rd wb_data
  // addr wdata byte_en ren wen halted
  logic [31:0] vec_mem [0:NUM_VECS*VEC_WORDS-1];

  always #2 clk = ~clk;

  rv32i_core rv32i_core_inst (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .rdata_i       (rdata),
    .pc_o          (pc),
    .mem_req_o     (mem_req),
    .wb_en_o       (wb_en),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .halted_o      (halted)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  // Address and data fields only matter when the matching strobe is expected
  task automatic compare_outputs(input int base);
    check_value("pc_o", pc, vec_mem[base+3]);
    check_value("wb_en_o", {31'd0, wb_en}, vec_mem[base+4]);
    if (vec_mem[base+4][0]) begin
      check_value("wb_rd_o", {27'd0, wb_rd}, vec_mem[base+5]);
      check_value("wb_data_o", wb_data, vec_mem[base+6]);
    end
    check_value("mem_req_o.ren", {31'd0, mem_req.ren}, vec_mem[base+10]);
    check_value("mem_req_o.wen", {31'd0, mem_req.wen}, vec_mem[base+11]);
    if (vec_mem[base+10][0] || vec_mem[base+11][0]) begin
      check_value("mem_req_o.addr", mem_req.addr, vec_mem[base+7]);
      check_value("mem_req_o.byte_en", {28'd0, mem_req.byte_en}, vec_mem[base+9]);
    end
    if (vec_mem[base+11][0]) begin
      check_value("mem_req_o.wdata", mem_req.wdata, vec_mem[base+8]);
    end
    check_value("halted_o", {31'd0, halted}, vec_mem[base+12]);
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    int base;

    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    rdata       = '0;

    $readmemh("dv/rv32i_core_vectors.hex", vec_mem);
    if ($isunknown(vec_mem[0]) || $isunknown(vec_mem[NUM_VECS*VEC_WORDS-1])) begin
      $display("Vector file is missing or holds fewer records than expected");
      $display("TB FAILED");
      $fatal(1, "Bad vector file");
    end

    repeat (3) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    for (int v = 0; v < NUM_VECS; v++) begin
      base        = v * VEC_WORDS;
      instr       = vec_mem[base];
      instr_valid = vec_mem[base+1][0];
      rdata       = vec_mem[base+2];
      // Sample just before the next rising edge
      #3;
      compare_outputs(base);
      @(posedge clk);
      #0.5;
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/rv32i_core_vectors.hex */
// instr valid rdata | expected: pc wb_en wb_rd wb_data addr wdata byte_en ren wen halted
// wb_rd/wb_data used only when wb_en is 1, addr/byte_en when ren or wen, wdata when wen
FFB00093 1 00000000 00000000 1 01 FFFFFFFB 00000000 00000000 0 0 0 0
12300113 1 00000000 00000004 1 02 00000123 00000000 00000000 0 0 0 0
4010D193 1 00000000 00000008 1 03 FFFFFFFD 00000000 00000000 0 0 0 0
0010D213 1 00000000 0000000C 1 04 7FFFFFFD 00000000 00000000 0 0 0 0
00411293 1 00000000 00000010 1 05 00001230 00000000 00000000 0 0 0 0
0000A313 1 00000000 00000014 1 06 00000001 00000000 00000000 0 0 0 0
0010B393 1 00000000 00000018 1 07 00000000 00000000 00000000 0 0 0 0
0FF14413 1 00000000 0000001C 1 08 000001DC 00000000 00000000 0 0 0 0
00F16493 1 00000000 00000020 1 09 0000012F 00000000 00000000 0 0 0 0
0F00F513 1 00000000 00000024 1 0A 000000F0 00000000 00000000 0 0 0 0
401105B3 1 00000000 00000028 1 0B 00000128 00000000 00000000 0 0 0 0
00208033 1 00000000 0000002C 1 00 0000011E 00000000 00000000 0 0 0 0
0020A633 1 00000000 00000030 1 0C 00000001 00000000 00000000 0 0 0 0
0020B6B3 1 00000000 00000034 1 0D 00000000 00000000 00000000 0 0 0 0
4020D733 1 00000000 00000038 1 0E FFFFFFFF 00000000 00000000 0 0 0 0
0020D7B3 1 00000000 0000003C 1 0F 1FFFFFFF 00000000 00000000 0 0 0 0
00206833 1 00000000 00000040 1 10 00000123 00000000 00000000 0 0 0 0
0020C8B3 1 00000000 00000044 1 11 FFFFFED8 00000000 00000000 0 0 0 0
00A0F933 1 00000000 00000048 1 12 000000F0 00000000 00000000 0 0 0 0
002119B3 1 00000000 0000004C 1 13 00000918 00000000 00000000 0 0 0 0
12345A37 1 00000000 00000050 1 14 12345000 00000000 00000000 0 0 0 0
00001A97 1 00000000 00000054 1 15 00001054 00000000 00000000 0 0 0 0
00800B6F 1 00000000 00000058 1 16 0000005C 00000000 00000000 0 0 0 0
F4E10BE7 1 00000000 00000060 1 17 00000064 00000000 00000000 0 0 0 0
01010463 1 00000000 00000070 0 00 00000000 00000000 00000000 0 0 0 0
00208463 1 00000000 00000078 0 00 00000000 00000000 00000000 0 0 0 0
00209463 1 00000000 0000007C 0 00 00000000 00000000 00000000 0 0 0 0
01011463 1 00000000 00000084 0 00 00000000 00000000 00000000 0 0 0 0
0020C463 1 00000000 00000088 0 00 00000000 00000000 00000000 0 0 0 0
00114463 1 00000000 00000090 0 00 00000000 00000000 00000000 0 0 0 0
00115463 1 00000000 00000094 0 00 00000000 00000000 00000000 0 0 0 0
0020D463 1 00000000 0000009C 0 00 00000000 00000000 00000000 0 0 0 0
00116463 1 00000000 000000A0 0 00 00000000 00000000 00000000 0 0 0 0
0020E463 1 00000000 000000A8 0 00 00000000 00000000 00000000 0 0 0 0
0020F463 1 00000000 000000AC 0 00 00000000 00000000 00000000 0 0 0 0
00117463 1 00000000 000000B4 0 00 00000000 00000000 00000000 0 0 0 0
00050C03 1 80F17F92 000000B8 1 18 FFFFFF92 000000F0 00000000 1 1 0 0
00150C03 1 80F17F92 000000BC 1 18 0000007F 000000F1 00000000 2 1 0 0
00250C03 1 80F17F92 000000C0 1 18 FFFFFFF1 000000F2 00000000 4 1 0 0
00350C03 1 80F17F92 000000C4 1 18 FFFFFF80 000000F3 00000000 8 1 0 0
00054C03 1 80F17F92 000000C8 1 18 00000092 000000F0 00000000 1 1 0 0
00154C03 1 80F17F92 000000CC 1 18 0000007F 000000F1 00000000 2 1 0 0
00254C03 1 80F17F92 000000D0 1 18 000000F1 000000F2 00000000 4 1 0 0
00354C03 1 80F17F92 000000D4 1 18 00000080 000000F3 00000000 8 1 0 0
00051C03 1 80F17F92 000000D8 1 18 00007F92 000000F0 00000000 3 1 0 0
00251C03 1 80F17F92 000000DC 1 18 FFFF80F1 000000F2 00000000 C 1 0 0
00055C03 1 80F17F92 000000E0 1 18 00007F92 000000F0 00000000 3 1 0 0
00255C03 1 80F17F92 000000E4 1 18 000080F1 000000F2 00000000 C 1 0 0
00452C03 1 80F17F92 000000E8 1 18 80F17F92 000000F4 00000000 F 1 0 0
018500A3 1 00000000 000000EC 0 00 00000000 000000F1 F17F9200 2 0 1 0
018501A3 1 00000000 000000F0 0 00 00000000 000000F3 92000000 8 0 1 0
01851123 1 00000000 000000F4 0 00 00000000 000000F2 7F920000 C 0 1 0
FF852823 1 00000000 000000F8 0 00 00000000 000000E0 80F17F92 F 0 1 0
00000013 0 00000000 000000FC 0 00 00000000 00000000 00000000 0 0 0 0
00000013 0 00000000 000000FC 0 00 00000000 00000000 00000000 0 0 0 0
00700C93 1 00000000 000000FC 1 19 00000007 00000000 00000000 0 0 0 0
7800D073 1 00000000 00000100 0 00 00000000 00000000 00000000 0 0 0 0
00100D13 1 00000000 00000100 0 00 00000000 00000000 00000000 0 0 0 1
FF852823 1 00000000 00000100 0 00 00000000 00000000 00000000 0 0 0 1
00050C03 1 80F17F92 00000100 0 00 00000000 00000000 00000000 0 0 0 1

/* tb.f */
hw/rv32i_pkg.sv
hw/rv32i_alu.sv
hw/rv32i_reg_file.sv
hw/rv32i_control_unit.sv
hw/rv32i_core.sv
dv/rv32i_core_sva.sv
dv/rv32i_core_tb.sv
